// File: tests/cache_patterns.txt
// columns: request address, expected outcome (1 hit, 0 miss), expected data word
// data word is the address in the low half and its inverse in the high half
// cold miss in set 5, then the rest of the line hits
000008A0 0 FFFFF75F000008A0
000008B0 1 FFFFF74F000008B0
000008A8 1 FFFFF757000008A8
000008B8 1 FFFFF747000008B8
// second tag in set 5 fills the other way, both stay resident
000010B8 0 FFFFEF47000010B8
000008A0 1 FFFFF75F000008A0
000010A0 1 FFFFEF5F000010A0
000008A8 1 FFFFF757000008A8
// third tag evicts the less recently used way
000018A0 0 FFFFE75F000018A0
000008B0 1 FFFFF74F000008B0
000010A8 0 FFFFEF57000010A8
000008B8 1 FFFFF747000008B8
000018A8 0 FFFFE757000018A8
000008A0 1 FFFFF75F000008A0
000018B0 1 FFFFE74F000018B0
// set 0, miss then a run of back-to-back hits
00002000 0 FFFFDFFF00002000
00002008 1 FFFFDFF700002008
00002010 1 FFFFDFEF00002010
00002018 1 FFFFDFE700002018
00002000 1 FFFFDFFF00002000
00002018 1 FFFFDFE700002018
000018A0 1 FFFFE75F000018A0
00002008 1 FFFFDFF700002008

// File: tb.f
+incdir+logic
logic/cachePkg.sv
logic/cacheCtrl.sv
logic/cacheTagArray.sv
logic/cacheDataArray.sv
logic/cacheRefill.sv
logic/cacheTop.sv
tests/cacheTb.sv

// File: run.sh
#!/bin/sh
# build the cache testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing -f tb.f --top-module cacheTb -o cacheSim &&
  ./obj_dir/cacheSim | tee /dev/stderr | grep -q "All tests passed" &&
  echo "simulation result: pass" ||
  { echo "simulation result: fail"; exit 1; }

// File: tests/cacheTb.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cacheTb import cachePkg::*; ();

  localparam int MAX_REQ    = 64;
  localparam int WAIT_LIMIT = 200;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       valid;
  cacheAddr_t addr;
  logic       addrOk;
  logic       dataOk;
  logic       dataNotOk;
  xlenWord_t  rdData;
  logic       cacheRdValid;
  cacheAddr_t cacheAddr;
  logic       rdDataValid = 1'b0;
  logic       rdLast = 1'b0;
  xlenWord_t  memData = '0;

  // three words per request for address, outcome and data
  logic [63:0] patMem [3*MAX_REQ];
  cacheAddr_t  reqAddr [MAX_REQ];
  logic        expHit [MAX_REQ];
  xlenWord_t   expWord [MAX_REQ];
  int          nReq;
  // request waiting for its answer or -1
  int          cur;
  integer      seed;

  cacheTop dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .addr_i         (addr),
    .valid_i        (valid),
    .addr_ok_o      (addrOk),
    .data_ok_o      (dataOk),
    .data_notok_o   (dataNotOk),
    .rd_data_o      (rdData),
    .cacheRdValid_o (cacheRdValid),
    .cacheAddr_o    (cacheAddr),
    .rdDataValid_i  (rdDataValid),
    .rdLast_i       (rdLast),
    .rdData_i       (memData)
  );

  always #5 clk = ~clk;

  task automatic abortRun();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic reportError(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    abortRun();
  endtask

  task automatic checkWord(input string what, input xlenWord_t got, input xlenWord_t exp);
    if (got !== exp) begin
      reportError($sformatf("%s: got %h, expected %h", what, got, exp));
    end
  endtask

  task automatic checkAddr(input string what, input cacheAddr_t got, input cacheAddr_t exp);
    if (got !== exp) begin
      reportError($sformatf("%s: got %h, expected %h", what, got, exp));
    end
  endtask

  task automatic checkOutcome(input string what, input logic gotHit, input logic wantHit);
    if (gotHit !== wantHit) begin
      reportError($sformatf("%s: got a %s, expected a %s", what,
                            gotHit ? "hit" : "miss", wantHit ? "hit" : "miss"));
    end
  endtask

  task automatic checkLevel(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      reportError($sformatf("%s: got %b, expected %b", what, got, exp));
    end
  endtask

  // address in the low half and its inverse in the high half
  function automatic xlenWord_t memoryWord(input cacheAddr_t a);
    return {~a, a};
  endfunction

  task automatic loadPatterns();
    // unread entries never look like an outcome word
    for (int i = 0; i < 3 * MAX_REQ; i++) begin
      patMem[i] = ~64'(i);
    end
    $readmemh("tests/cache_patterns.txt", patMem);
    nReq = 0;
    // an outcome word other than 0 or 1 ends the list
    while (nReq < MAX_REQ && patMem[3*nReq+1] <= 64'd1) begin
      reqAddr[nReq] = patMem[3*nReq][`ADDR_W-1:0];
      expHit[nReq]  = patMem[3*nReq+1][0];
      expWord[nReq] = patMem[3*nReq+2];
      nReq++;
    end
  endtask

  // four beats with a gap of 0 to 3 cycles before each
  task automatic serveLine();
    cacheAddr_t base;
    int         gap;
    if (cur < 0) begin
      reportError("line request with no outstanding miss");
    end
    base = {reqAddr[cur][`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
    checkAddr("cacheAddr_o", cacheAddr, base);
    for (int b = 0; b < `BEATS; b++) begin
      gap = int'($unsigned($random(seed)) % 4);
      for (int g = 0; g < gap; g++) begin
        rdDataValid = 1'b0;
        rdLast      = 1'b0;
        @(negedge clk);
      end
      rdDataValid = 1'b1;
      rdLast      = (b == `BEATS - 1);
      memData     = memoryWord(base + cacheAddr_t'(8 * b));
      @(negedge clk);
    end
    rdDataValid = 1'b0;
    rdLast      = 1'b0;
  endtask

  always @(negedge clk) begin
    if (rst_n && cacheRdValid) begin
      serveLine();
    end
  end

  initial begin
    int   next;
    int   cycle;
    int   acceptCycle;
    int   idleCycles;
    int   responses;
    logic notokSeen;
    logic gotResp;
    logic prevHit;
    rst_n       = 1'b0;
    valid       = 1'b0;
    addr        = '0;
    seed        = 32'hb0a0;
    cur         = -1;
    next        = 0;
    cycle       = 0;
    acceptCycle = 0;
    idleCycles  = 0;
    responses   = 0;
    notokSeen   = 1'b0;
    prevHit     = 1'b0;
    loadPatterns();
    if (nReq == 0) begin
      $display("the pattern file held no requests");
      abortRun();
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    checkLevel("addr_ok_o after reset", addrOk, 1'b1);
    checkLevel("data_ok_o after reset", dataOk, 1'b0);
    checkLevel("data_notok_o after reset", dataNotOk, 1'b0);
    checkLevel("cacheRdValid_o after reset", cacheRdValid, 1'b0);

    while (responses < nReq) begin
      @(negedge clk);
      cycle++;
      idleCycles++;
      gotResp = 1'b0;
      if (cur >= 0) begin
        if (dataNotOk) begin
          notokSeen = 1'b1;
        end
        if (expHit[cur]) begin
          checkLevel($sformatf("data_notok_o for request %0d", cur), dataNotOk, 1'b0);
        end
        if (dataOk) begin
          checkLevel($sformatf("data_notok_o with the answer to request %0d", cur),
                     dataNotOk, 1'b0);
          checkWord($sformatf("rd_data_o for request %0d", cur), rdData, expWord[cur]);
          // a hit answers one cycle after acceptance without data_notok_o
          checkOutcome($sformatf("outcome of request %0d", cur),
                       (cycle - acceptCycle == 1) && !notokSeen, expHit[cur]);
          // only a miss raises data_notok_o
          checkLevel($sformatf("data_notok_o raised for request %0d", cur),
                     notokSeen, !expHit[cur]);
          prevHit    = expHit[cur];
          gotResp    = 1'b1;
          cur        = -1;
          responses++;
          idleCycles = 0;
        end else if (notokSeen) begin
          checkLevel($sformatf("data_notok_o while request %0d is refilled", cur),
                     dataNotOk, 1'b1);
        end
      end else if (dataOk) begin
        reportError("data_ok_o with no request outstanding");
      end
      if (next < nReq) begin
        valid = 1'b1;
        addr  = reqAddr[next];
        if (gotResp && prevHit && expHit[next]) begin
          checkLevel("addr_ok_o between back-to-back hits", addrOk, 1'b1);
        end
        if (addrOk) begin
          if (cur >= 0) begin
            reportError($sformatf("request %0d accepted while %0d is outstanding", next, cur));
          end
          cur         = next;
          acceptCycle = cycle;
          notokSeen   = 1'b0;
          next++;
          idleCycles  = 0;
        end
      end else begin
        valid = 1'b0;
        addr  = '0;
      end
      if (idleCycles > WAIT_LIMIT) begin
        $display("timeout waiting for acceptance or a response after request %0d", next);
        abortRun();
      end
    end

    valid = 1'b0;
    @(negedge clk);
    checkLevel("cacheRdValid_o at the end", cacheRdValid, 1'b0);
    $display("All tests passed");
    $finish;
  end

endmodule

// File: logic/cacheTop.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cacheTop import cachePkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // pipeline side
  input  cacheAddr_t addr_i,
  input  logic       valid_i,
  output logic       addr_ok_o,
  output logic       data_ok_o,
  output logic       data_notok_o,
  output xlenWord_t  rd_data_o,
  // memory side
  output logic       cacheRdValid_o,
  output cacheAddr_t cacheAddr_o,
  input  logic       rdDataValid_i,
  input  logic       rdLast_i,
  input  xlenWord_t  rdData_i
);

  logic                   hit;
  logic                   hitWay;
  logic                   victimWay;
  logic                   lineDone;
  logic                   lookupEn;
  index_t                 lookupIndex;
  tag_t                   reqTag;
  index_t                 reqIndex;
  logic [`WORD_SEL_W-1:0] wordSel;
  logic                   refillStart;
  logic                   fillEn;
  logic                   fillFlag;
  line_t                  refillLine;
  line_t                  way0Line;
  line_t                  way1Line;
  line_t                  sourceLine;

  cacheCtrl ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .addr_i        (addr_i),
    .hit_i         (hit),
    .lineDone_i    (lineDone),
    .addr_ok_o     (addr_ok_o),
    .data_ok_o     (data_ok_o),
    .data_notok_o  (data_notok_o),
    .lookupEn_o    (lookupEn),
    .lookupIndex_o (lookupIndex),
    .reqTag_o      (reqTag),
    .reqIndex_o    (reqIndex),
    .wordSel_o     (wordSel),
    .refillStart_o (refillStart),
    .fillEn_o      (fillEn),
    .fillFlag_o    (fillFlag)
  );

  cacheTagArray tags (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqTag_i    (reqTag),
    .reqIndex_i  (reqIndex),
    .lookupHit_i (data_ok_o),
    .fillEn_i    (fillEn),
    .hit_o       (hit),
    .hitWay_o    (hitWay),
    .victimWay_o (victimWay)
  );

  cacheDataArray data (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupEn_i    (lookupEn),
    .lookupIndex_i (lookupIndex),
    .fillEn_i      (fillEn),
    .fillIndex_i   (reqIndex),
    .fillWay_i     (victimWay),
    .fillLine_i    (refillLine),
    .way0Line_o    (way0Line),
    .way1Line_o    (way1Line)
  );

  cacheRefill refill (
    .clk            (clk),
    .rst_n          (rst_n),
    .refillStart_i  (refillStart),
    .reqTag_i       (reqTag),
    .reqIndex_i     (reqIndex),
    .rdDataValid_i  (rdDataValid_i),
    .rdLast_i       (rdLast_i),
    .rdData_i       (rdData_i),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o),
    .lineDone_o     (lineDone),
    .line_o         (refillLine)
  );

  // array read predates the fill, so bypass from the refill buffer
  always_comb begin
    if (fillFlag) begin
      sourceLine = refillLine;
    end else if (hitWay) begin
      sourceLine = way1Line;
    end else begin
      sourceLine = way0Line;
    end
  end

  assign rd_data_o = sourceLine[wordSel*`XLEN +: `XLEN];

endmodule

// File: logic/cacheRefill.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cacheRefill import cachePkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       refillStart_i,
  input  tag_t       reqTag_i,
  input  index_t     reqIndex_i,
  input  logic       rdDataValid_i,
  input  logic       rdLast_i,
  input  xlenWord_t  rdData_i,
  output logic       cacheRdValid_o,
  output cacheAddr_t cacheAddr_o,
  output logic       lineDone_o,
  output line_t      line_o
);

  localparam int CNT_W = $clog2(`BEATS);

  logic [CNT_W-1:0] beatCnt;
  logic             beatTaken;

  // beats only count while a request is open
  assign beatTaken  = cacheRdValid_o && rdDataValid_i;
  assign lineDone_o = beatTaken && rdLast_i;

  // line base address, offset bits zero
  assign cacheAddr_o = {reqTag_i, reqIndex_i, {`OFFSET_W{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cacheRdValid_o <= 1'b0;
      beatCnt        <= '0;
    end else if (refillStart_i) begin
      cacheRdValid_o <= 1'b1;
      beatCnt        <= '0;
    end else if (beatTaken) begin
      beatCnt <= beatCnt + 1'b1;
      if (rdLast_i) begin
        cacheRdValid_o <= 1'b0;
      end
    end
  end

  // each beat lands in its own slot, low word first
  // buffer holds after the last beat for fill and bypass
  always_ff @(posedge clk) begin
    if (beatTaken) begin
      line_o[beatCnt*`XLEN +: `XLEN] <= rdData_i;
    end
  end

endmodule

// File: logic/cacheDataArray.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cacheDataArray import cachePkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   lookupEn_i,
  input  index_t lookupIndex_i,
  input  logic   fillEn_i,
  input  index_t fillIndex_i,
  input  logic   fillWay_i,
  input  line_t  fillLine_i,
  output line_t  way0Line_o,
  output line_t  way1Line_o
);

  // behavioral stand-in for the line SRAMs
  line_t wayMem [2][`SETS];

  // whole-line write into the chosen way
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      wayMem[fillWay_i][fillIndex_i] <= fillLine_i;
    end
  end

  // registered read of both ways, output valid the cycle after lookupEn
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      way0Line_o <= '0;
      way1Line_o <= '0;
    end else if (lookupEn_i) begin
      way0Line_o <= wayMem[0][lookupIndex_i];
      way1Line_o <= wayMem[1][lookupIndex_i];
    end
  end

endmodule

// File: logic/cacheTagArray.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cacheTagArray import cachePkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  tag_t   reqTag_i,
  input  index_t reqIndex_i,
  input  logic   lookupHit_i,
  input  logic   fillEn_i,
  output logic   hit_o,
  output logic   hitWay_o,
  output logic   victimWay_o
);

  // tag storage per way and set
  tag_t tagMem [2][`SETS];

  // valid bit per way per set
  logic [1:0][`SETS-1:0] validMem;

  // lru bit per set points at the next victim
  logic [`SETS-1:0] lru;

  logic [1:0] wayHit;
  logic [1:0] wayValid;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayValid[w] = validMem[w][reqIndex_i];
      wayHit[w]   = wayValid[w] && (tagMem[w][reqIndex_i] == reqTag_i);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // empty way first, way 0 before way 1, then lru
  always_comb begin
    if (!wayValid[0]) begin
      victimWay_o = 1'b0;
    end else if (!wayValid[1]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = lru[reqIndex_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validMem <= '0;
      lru      <= '0;
    end else if (fillEn_i) begin
      validMem[victimWay_o][reqIndex_i] <= 1'b1;
      lru[reqIndex_i]                   <= ~victimWay_o;
    end else if (lookupHit_i) begin
      // point away from the way just used
      lru[reqIndex_i] <= ~hitWay_o;
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagMem[victimWay_o][reqIndex_i] <= reqTag_i;
    end
  end

endmodule

// File: logic/cacheCtrl.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cacheCtrl import cachePkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   valid_i,
  input  cacheAddr_t             addr_i,
  input  logic                   hit_i,
  input  logic                   lineDone_i,
  output logic                   addr_ok_o,
  output logic                   data_ok_o,
  output logic                   data_notok_o,
  output logic                   lookupEn_o,
  output index_t                 lookupIndex_o,
  output tag_t                   reqTag_o,
  output index_t                 reqIndex_o,
  output logic [`WORD_SEL_W-1:0] wordSel_o,
  output logic                   refillStart_o,
  output logic                   fillEn_o,
  output logic                   fillFlag_o
);

  cacheState_e state;
  cacheState_e nextState;
  cacheAddr_t  reqAddr;
  logic        accept;
  logic        compareEn;

  assign compareEn = (state == COMPARE);

  // new request taken when idle or when the current lookup hits
  assign addr_ok_o = (state == IDLE) || (compareEn && hit_i);
  assign accept    = valid_i && addr_ok_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (accept) begin
          nextState = COMPARE;
        end
      end
      COMPARE: begin
        if (!hit_i) begin
          nextState = REFILL;
        end else if (!valid_i) begin
          nextState = IDLE;
        end
      end
      REFILL: begin
        // wait for the last beat
        if (lineDone_i) begin
          nextState = FILL;
        end
      end
      FILL: begin
        nextState = COMPARE;
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  // request latch, only moves on acceptance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqAddr <= '0;
    end else if (accept) begin
      reqAddr <= addr_i;
    end
  end

  // marks the compare cycle right after a fill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fillFlag_o <= 1'b0;
    end else begin
      fillFlag_o <= (state == FILL);
    end
  end

  assign reqTag_o   = reqAddr[`ADDR_W-1 -: `TAG_W];
  assign reqIndex_o = reqAddr[`OFFSET_W +: `INDEX_W];
  assign wordSel_o  = reqAddr[`OFFSET_W-1 -: `WORD_SEL_W];

  // data array read starts in the acceptance cycle
  assign lookupEn_o    = accept;
  assign lookupIndex_o = addr_i[`OFFSET_W +: `INDEX_W];

  assign data_ok_o     = compareEn && hit_i;
  assign data_notok_o  = (compareEn && !hit_i) || (state == REFILL) || (state == FILL);
  assign refillStart_o = compareEn && !hit_i;
  assign fillEn_o      = (state == FILL);

endmodule

// File: logic/cachePkg.sv
`include "cache_defines.svh"

package cachePkg;

  // controller states
  typedef enum logic [2:0] {
    IDLE    = 3'b000,
    COMPARE = 3'b001,
    REFILL  = 3'b010,
    FILL    = 3'b011
  } cacheState_e;

  // one XLEN data word
  typedef logic [`XLEN-1:0]    xlenWord_t;

  // request address as seen by the pipeline
  typedef logic [`ADDR_W-1:0]  cacheAddr_t;

  typedef logic [`TAG_W-1:0]   tag_t;
  typedef logic [`INDEX_W-1:0] index_t;

  // full line, beat 0 in the low word
  typedef logic [`LINE_W-1:0]  line_t;

endpackage

// File: logic/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// request and data widths
`define ADDR_W      32
`define XLEN        64

// address split: tag 31..11, index 10..5, offset 4..0
`define TAG_W       21
`define INDEX_W     6
`define OFFSET_W    5
// word in line, bits 4..3 of the offset
`define WORD_SEL_W  2

// geometry
`define SETS        64
`define BEATS       4
`define LINE_W      256

`endif
